// File: flist.f
src/coupler_pkg.sv
src/victim_entry.sv
src/victim_select.sv
src/main_cache.sv
src/coupler_ctrl.sv
src/cpu_coupler.sv
sim/clk_gen.sv
sim/cpu_coupler_checker.sv
sim/tb_cpu_coupler.sv

// File: sim/clk_gen.sv
// Testbench clock source and synchronous reset pulse
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter real PERIOD_NS    = 40.0,
   parameter int  RESET_CYCLES = 3
) (
   output logic sysclk,
   output logic rst_n
);

   initial
   begin
      sysclk = 1'b0;
      forever
         #(PERIOD_NS / 2.0) sysclk = ~sysclk;
   end

   // Reset is released just after an edge, like every other input
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge sysclk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: sim/cpu_coupler_checker.sv
// Concurrent assertions on the coupler strobes and triggers
`timescale 1ns/1ps
`default_nettype none

module cpu_coupler_checker (
   input logic sysclk,
   input logic rst_n,
   input logic st_busy,
   input logic store_trigger,
   input logic load_trigger,
   input logic rd_valid
);

   int unsigned assert_failures = 0;

   // Strobes come out of reset low
   a_reset_quiet: assert property (@(posedge sysclk)
      !rst_n |=> (!store_trigger && !load_trigger && !rd_valid))
   else
   begin
      $error("store_trigger, load_trigger or rd_valid high right after reset");
      assert_failures++;
   end

   a_store_pulse: assert property (@(posedge sysclk) disable iff (!rst_n)
      store_trigger |=> !store_trigger)
   else
   begin
      $error("store_trigger held longer than one cycle");
      assert_failures++;
   end

   a_load_pulse: assert property (@(posedge sysclk) disable iff (!rst_n)
      load_trigger |=> !load_trigger)
   else
   begin
      $error("load_trigger held longer than one cycle");
      assert_failures++;
   end

   // A trigger follows an edge on which st_busy was seen low
   a_busy_blocks: assert property (@(posedge sysclk) disable iff (!rst_n)
      (store_trigger || load_trigger) |-> !$past(st_busy))
   else
   begin
      $error("trigger issued although st_busy was high");
      assert_failures++;
   end

   a_no_overlap: assert property (@(posedge sysclk) disable iff (!rst_n)
      !(rd_valid && load_trigger))
   else
   begin
      $error("rd_valid and load_trigger high in the same cycle");
      assert_failures++;
   end

endmodule

`default_nettype wire

// File: sim/tb_cpu_coupler.sv
// Testbench for cpu_coupler with memory-side model, reference cache model and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_coupler;

   localparam int MAIN_LINES     = 64;
   localparam int VICTIM_LINES   = 4;
   // Roughly 40 requests at up to 30 cycles each, with a wide margin
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int HOLD_CYCLES    = 4;

   logic                    sysclk;
   logic                    rst_n;
   logic                    nmreq;
   logic                    nrw;
   logic [1:0]              mas;
   coupler_pkg::addr_t      addr;
   coupler_pkg::word_t      wdata;
   coupler_pkg::word_t      rdata;
   logic                    rd_valid;
   logic                    nwait;
   logic                    st_busy;
   logic                    ld_busy;
   logic                    fill_req;
   coupler_pkg::fill_beat_t fill;
   logic                    store_trigger;
   logic                    load_trigger;
   coupler_pkg::wbuf_t      wbuf;

   // Memory-side model state
   coupler_pkg::word_t      mem_store [logic [29:0]];
   integer                  seed;
   logic                    busy_hold;
   int                      busy_left;
   logic                    filling;
   int                      fill_gap;
   int                      beat;
   coupler_pkg::line_addr_t fill_line;
   int unsigned             ld_trig_count;
   int unsigned             st_trig_count;

   // Reference cache contents, tags only since data comes from memory
   logic                    ref_mvalid [MAIN_LINES];
   coupler_pkg::line_addr_t ref_mtag   [MAIN_LINES];
   logic                    ref_vvalid [VICTIM_LINES];
   coupler_pkg::line_addr_t ref_vtag   [VICTIM_LINES];
   int                      ref_fifo;

   int                      error_count;
   int                      test_errors;
   int                      test_count;
   int                      failed_tests;
   string                   test_name;
   int                      cycle_count;

   clk_gen #(
      .PERIOD_NS    (40.0),
      .RESET_CYCLES (3)
   ) u_clk_gen (
      .sysclk (sysclk),
      .rst_n  (rst_n)
   );

   cpu_coupler #(
      .MAIN_LINES   (MAIN_LINES),
      .VICTIM_LINES (VICTIM_LINES)
   ) u_cpu_coupler (
      .sysclk        (sysclk),
      .rst_n         (rst_n),
      .nmreq         (nmreq),
      .nrw           (nrw),
      .mas           (mas),
      .addr          (addr),
      .wdata         (wdata),
      .rdata         (rdata),
      .rd_valid      (rd_valid),
      .nwait         (nwait),
      .st_busy       (st_busy),
      .ld_busy       (ld_busy),
      .fill_req      (fill_req),
      .fill          (fill),
      .store_trigger (store_trigger),
      .load_trigger  (load_trigger),
      .wbuf          (wbuf)
   );

   bind cpu_coupler cpu_coupler_checker u_checker (
      .sysclk        (sysclk),
      .rst_n         (rst_n),
      .st_busy       (st_busy),
      .store_trigger (store_trigger),
      .load_trigger  (load_trigger),
      .rd_valid      (rd_valid)
   );

   // Untouched words hold a pattern derived from the word address
   function automatic coupler_pkg::word_t mem_read(input logic [29:0] wa);
      if (mem_store.exists(wa))
         return mem_store[wa];
      return {2'b00, wa} * 32'h9E3779B1;
   endfunction

   function automatic coupler_pkg::word_t expected_load(input coupler_pkg::addr_t a,
                                                        input logic is_word);
      coupler_pkg::word_t w;
      w = mem_read(a[31:2]);
      return is_word ? w : {24'h000000, w[{a[1:0], 3'b000} +: 8]};
   endfunction

   // Tracks main and victim tags by the cache rules and returns 1 for a miss
   function automatic logic ref_load(input coupler_pkg::addr_t a);
      coupler_pkg::line_addr_t la;
      int                      idx;
      int                      hit_entry;
      la        = a[31:4];
      idx       = la % MAIN_LINES;
      hit_entry = -1;
      if (ref_mvalid[idx] && ref_mtag[idx] == la)
         return 1'b0;
      for (int i = VICTIM_LINES - 1; i >= 0; i--)
      begin
         if (ref_vvalid[i] && ref_vtag[i] == la)
            hit_entry = i;
      end
      if (hit_entry >= 0)
      begin
         // Victim line and main line trade places
         ref_vvalid[hit_entry] = ref_mvalid[idx];
         ref_vtag[hit_entry]   = ref_mtag[idx];
         ref_mvalid[idx]       = 1'b1;
         ref_mtag[idx]         = la;
         return 1'b0;
      end
      if (ref_mvalid[idx])
      begin
         ref_vvalid[ref_fifo] = 1'b1;
         ref_vtag[ref_fifo]   = ref_mtag[idx];
         ref_fifo             = (ref_fifo + 1) % VICTIM_LINES;
      end
      ref_mvalid[idx] = 1'b1;
      ref_mtag[idx]   = la;
      return 1'b1;
   endfunction

   task automatic apply_store(input coupler_pkg::wbuf_t wb);
      coupler_pkg::word_t w;
      w = mem_read(wb.addr[31:2]);
      if (wb.is_byte)
         w[{wb.addr[1:0], 3'b000} +: 8] = wb.data[{wb.addr[1:0], 3'b000} +: 8];
      else
         w = wb.data;
      mem_store[wb.addr[31:2]] = w;
   endtask

   task automatic check_hex(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
         error_count++;
         test_errors++;
      end
   endtask

   // Memory side, stepped 1 ns after each rising edge
   initial
   begin : memory_side
      logic [31:0] r;
      logic        hold_now;
      seed          = 96509;
      st_busy       = 1'b0;
      ld_busy       = 1'b0;
      fill_req      = 1'b0;
      fill          = '0;
      busy_hold     = 1'b0;
      busy_left     = 0;
      filling       = 1'b0;
      ld_trig_count = 0;
      st_trig_count = 0;
      forever
      begin
         @(posedge sysclk);
         // Stall request as it stood on the edge
         hold_now = busy_hold;
         #1;
         if (store_trigger === 1'b1)
         begin
            apply_store(wbuf);
            st_trig_count++;
         end
         if (load_trigger === 1'b1)
         begin
            ld_trig_count++;
            fill_line = wbuf.addr[31:4];
            filling   = 1'b1;
            beat      = 0;
            r         = $random(seed);
            fill_gap  = r[1:0];
            ld_busy   = 1'b1;
            fill_req  = 1'b0;
         end
         else if (filling)
         begin
            if (fill_gap > 0)
            begin
               fill_gap--;
               fill_req = 1'b0;
            end
            else if (beat < 4)
            begin
               // Beats go out in order 0 to 3
               fill_req    = 1'b1;
               fill.offset = beat[1:0];
               fill.data   = mem_read({fill_line, beat[1:0]});
               beat++;
            end
            else
            begin
               fill_req = 1'b0;
               ld_busy  = 1'b0;
               filling  = 1'b0;
            end
         end
         if (hold_now)
            st_busy = 1'b1;
         else if (busy_left > 0)
         begin
            st_busy = 1'b1;
            busy_left--;
         end
         else
         begin
            r       = $random(seed);
            st_busy = 1'b0;
            if (r[2:0] == 3'd0)
               busy_left = r[4:3] + 1;
         end
      end
   end

   // Drives one request and waits for its completion strobe
   task automatic bus_request(input logic write, input logic is_word,
                              input coupler_pkg::addr_t a, input coupler_pkg::word_t d,
                              input int hold, output int waits,
                              output coupler_pkg::word_t got_rdata,
                              output coupler_pkg::wbuf_t got_wbuf);
      logic done;
      if (hold > 0)
      begin
         busy_hold = 1'b1;
         @(posedge sysclk);
         #1;
      end
      nmreq = 1'b0;
      nrw   = write;
      mas   = is_word ? 2'b10 : 2'b00;
      addr  = a;
      wdata = d;
      waits = 0;
      // With st_busy forced high the request has to stall
      repeat (hold)
      begin
         @(posedge sysclk);
         #1;
         waits++;
         check_hex("nwait", 64'h0, nwait);
         check_hex("store_trigger", 64'h0, store_trigger);
         check_hex("load_trigger", 64'h0, load_trigger);
      end
      busy_hold = 1'b0;
      done      = 1'b0;
      while (!done)
      begin
         @(posedge sysclk);
         #1;
         waits++;
         done = write ? store_trigger : rd_valid;
      end
      got_rdata = rdata;
      got_wbuf  = wbuf;
      nmreq     = 1'b1;
      // One spare cycle brings the controller back to idle
      @(posedge sysclk);
      #1;
   endtask

   task automatic do_load(input coupler_pkg::addr_t a, input logic is_word, input int hold);
      int unsigned        trig_before;
      logic               exp_miss;
      int                 waits;
      coupler_pkg::word_t got;
      coupler_pkg::wbuf_t wb;
      trig_before = ld_trig_count;
      exp_miss    = ref_load(a);
      bus_request(1'b0, is_word, a, '0, hold, waits, got, wb);
      check_hex("rdata", expected_load(a, is_word), got);
      check_hex("load_trigger count", exp_miss, ld_trig_count - trig_before);
      if (!exp_miss)
         check_hex("load hit latency", 64'd1, waits);
   endtask

   task automatic do_store(input coupler_pkg::addr_t a, input logic is_word,
                           input coupler_pkg::word_t d, input int hold);
      int unsigned        st_before;
      int unsigned        ld_before;
      int                 waits;
      coupler_pkg::word_t got;
      coupler_pkg::wbuf_t wb;
      st_before = st_trig_count;
      ld_before = ld_trig_count;
      bus_request(1'b1, is_word, a, d, hold, waits, got, wb);
      check_hex("store_trigger count", 64'd1, st_trig_count - st_before);
      check_hex("load_trigger count", 64'd0, ld_trig_count - ld_before);
      check_hex("wbuf.addr", a, wb.addr);
      check_hex("wbuf.data", is_word ? d : {4{d[7:0]}}, wb.data);
      check_hex("wbuf.is_byte", !is_word, wb.is_byte);
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      test_count++;
   endtask

   task automatic finish_test();
      if (test_errors != 0)
         failed_tests++;
      $display("Test %0d %-24s %s", test_count, test_name,
               (test_errors == 0) ? "passed" : "failed");
   endtask

   initial
   begin : watchdog
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge sysclk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, a request never completed", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   initial
   begin : stimulus
      coupler_pkg::addr_t base;
      nmreq        = 1'b1;
      nrw          = 1'b0;
      mas          = 2'b10;
      addr         = '0;
      wdata        = '0;
      error_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      ref_fifo     = 0;
      for (int i = 0; i < MAIN_LINES; i++)
         ref_mvalid[i] = 1'b0;
      for (int i = 0; i < VICTIM_LINES; i++)
         ref_vvalid[i] = 1'b0;
      wait (rst_n === 1'b1);
      @(posedge sysclk);
      #1;

      start_test("load miss");
      do_load(32'h0000_1234, 1'b1, 0);
      do_load(32'h0000_2467, 1'b0, 0);
      finish_test();

      start_test("load hit");
      do_load(32'h0000_1234, 1'b1, 0);
      do_load(32'h0000_1236, 1'b0, 0);
      do_load(32'h0000_123C, 1'b1, 0);
      do_load(32'h0000_2467, 1'b0, 0);
      finish_test();

      start_test("byte and word store");
      do_store(32'h0000_1235, 1'b0, 32'hFFFF_FF5A, 0);
      do_store(32'h0000_1238, 1'b1, 32'hDEAD_BEEF, 0);
      do_load(32'h0000_1234, 1'b1, 0);
      do_load(32'h0000_1235, 1'b0, 0);
      do_load(32'h0000_1238, 1'b1, 0);
      // Store miss goes to memory only
      do_store(32'h0000_5000, 1'b1, 32'h0BAD_F00D, 0);
      do_load(32'h0000_5000, 1'b1, 0);
      finish_test();

      start_test("st_busy stall");
      do_store(32'h0000_1230, 1'b1, 32'h1122_3344, HOLD_CYCLES);
      do_load(32'h0000_3004, 1'b1, HOLD_CYCLES);
      do_load(32'h0000_1230, 1'b1, 0);
      finish_test();

      start_test("victim swap");
      do_load(32'h0000_4040, 1'b1, 0);
      do_load(32'h0000_4440, 1'b1, 0);
      do_load(32'h0000_4044, 1'b1, 0);
      do_load(32'h0000_4448, 1'b1, 0);
      finish_test();

      start_test("victim fifo");
      base = 32'h0001_0090;
      // Six lines on index 9 push five lines through the victim entries
      for (int k = 0; k < 6; k++)
         do_load(base + k * 32'h400, 1'b1, 0);
      do_load(base, 1'b1, 0);
      do_load(base + 2 * 32'h400, 1'b1, 0);
      finish_test();

      $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
               test_count, failed_tests, error_count,
               u_cpu_coupler.u_checker.assert_failures);
      if (error_count == 0 && u_cpu_coupler.u_checker.assert_failures == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/coupler_ctrl.sv
// Coupler FSM for loads, stores, fills, evictions and swaps, with the victim FIFO and write buffer
`timescale 1ns/1ps
`default_nettype none

module coupler_ctrl #(
   parameter int VICTIM_LINES = 4
) (
   input  logic                            sysclk,
   input  logic                            rst_n,
   input  logic                            nmreq,
   input  coupler_pkg::cpu_req_t           req,
   input  logic                            st_busy,
   input  logic                            ld_busy,
   input  logic                            fill_req,
   input  coupler_pkg::fill_beat_t         fill,
   input  logic                            mhit,
   input  logic                            mvalid,
   input  coupler_pkg::line_t              mline,
   input  coupler_pkg::line_addr_t         mtag,
   input  logic                            vhit,
   input  logic [$clog2(VICTIM_LINES)-1:0] vsel,
   input  coupler_pkg::line_t              vline,
   output logic                            m_write,
   output logic                            m_fill,
   output logic                            m_install,
   output logic                            m_swap,
   output logic [VICTIM_LINES-1:0]         victim_we,
   output logic                            v_update,
   output coupler_pkg::line_t              evict_line,
   output coupler_pkg::line_addr_t         evict_tag,
   output logic                            evict_valid,
   output coupler_pkg::word_t              rdata,
   output logic                            rd_valid,
   output logic                            nwait,
   output logic                            store_trigger,
   output logic                            load_trigger,
   output coupler_pkg::wbuf_t              wbuf
);

   localparam int SEL_W = $clog2(VICTIM_LINES);

   coupler_pkg::ctrl_state_t state;
   coupler_pkg::ctrl_state_t state_nxt;
   logic [SEL_W-1:0]         fifo_ptr;
   logic [3:0]               beats_q;
   logic [3:0]               beat_now;
   logic                     req_load;
   logic                     accept_load;
   logic                     load_miss;
   logic                     accept_store;
   logic                     launch_miss;
   logic                     fill_done;
   logic                     do_swap;
   logic                     do_evict;
   coupler_pkg::line_t       read_line;

   assign req_load    = (state == coupler_pkg::st_idle) && !nmreq && !req.write;
   assign accept_load = req_load && (mhit || vhit);
   assign load_miss   = req_load && !mhit && !vhit;

   // A store waits out st_busy before it is taken
   assign accept_store = !nmreq && req.write && !st_busy &&
                         ((state == coupler_pkg::st_idle) ||
                          (state == coupler_pkg::st_store_wait));

   assign launch_miss = !st_busy && (load_miss || (state == coupler_pkg::st_fill_wait));

   // Fill ends once ld_busy drops and every word of the line has arrived
   assign beat_now  = fill_req ? (4'b0001 << fill.offset) : 4'b0000;
   assign fill_done = (state == coupler_pkg::st_filling) && !ld_busy &&
                      (&(beats_q | beat_now));

   assign do_swap  = accept_load && !mhit;
   assign do_evict = load_miss && mvalid;

   assign m_write   = accept_store && mhit;
   assign v_update  = accept_store && !mhit && vhit;
   assign m_fill    = (state == coupler_pkg::st_filling) && fill_req;
   assign m_install = (state == coupler_pkg::st_load_end);
   assign m_swap    = do_swap;

   // The outgoing main line goes to the victim cache on a swap or an eviction
   assign evict_line  = mline;
   assign evict_tag   = mtag;
   assign evict_valid = mvalid;

   always_comb
   begin
      victim_we = '0;
      if (do_swap)
         victim_we[vsel] = 1'b1;
      else if (do_evict)
         victim_we[fifo_ptr] = 1'b1;
   end

   assign read_line = do_swap ? vline : mline;
   assign nwait     = (state == coupler_pkg::st_idle) || (state == coupler_pkg::st_done);

   always_comb
   begin
      state_nxt = state;
      case (state)
         coupler_pkg::st_idle:
            if (accept_store || accept_load)
               state_nxt = coupler_pkg::st_done;
            else if (!nmreq && req.write)
               state_nxt = coupler_pkg::st_store_wait;
            else if (load_miss)
               state_nxt = launch_miss ? coupler_pkg::st_filling : coupler_pkg::st_fill_wait;
         coupler_pkg::st_store_wait:
            if (accept_store)
               state_nxt = coupler_pkg::st_done;
         coupler_pkg::st_fill_wait:
            if (launch_miss)
               state_nxt = coupler_pkg::st_filling;
         coupler_pkg::st_filling:
            if (fill_done)
               state_nxt = coupler_pkg::st_load_end;
         coupler_pkg::st_load_end:
            state_nxt = coupler_pkg::st_done;
         default:
            state_nxt = coupler_pkg::st_idle;
      endcase
   end

   always_ff @(posedge sysclk)
   begin
      if (!rst_n)
      begin
         state         <= coupler_pkg::st_idle;
         fifo_ptr      <= '0;
         beats_q       <= '0;
         store_trigger <= 1'b0;
         load_trigger  <= 1'b0;
         rd_valid      <= 1'b0;
      end
      else
      begin
         state         <= state_nxt;
         store_trigger <= accept_store;
         load_trigger  <= launch_miss;
         rd_valid      <= accept_load || (state == coupler_pkg::st_load_end);
         // Oldest victim entry is replaced next
         if (do_evict)
            fifo_ptr <= (fifo_ptr == SEL_W'(VICTIM_LINES - 1)) ? '0 : fifo_ptr + 1'b1;
         if (launch_miss)
            beats_q <= '0;
         else if (state == coupler_pkg::st_filling)
            beats_q <= beats_q | beat_now;
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (accept_store)
      begin
         wbuf.addr    <= req.addr;
         wbuf.data    <= req.is_word ? req.wdata : {4{req.wdata[7:0]}};
         wbuf.is_byte <= !req.is_word;
      end
      else if (launch_miss)
         wbuf.addr <= req.addr;
      if (accept_load || (state == coupler_pkg::st_load_end))
         rdata <= req.is_word ? coupler_pkg::extract_word(read_line, req.addr[3:2])
                              : coupler_pkg::extract_byte(read_line, req.addr[3:0]);
   end

endmodule

`default_nettype wire

// File: src/coupler_pkg.sv
// Coupler widths, bus and buffer structs, controller states, line merge and extract functions
`default_nettype none

package coupler_pkg;

   typedef logic [31:0]  addr_t;
   typedef logic [31:0]  word_t;
   typedef logic [127:0] line_t;
   typedef logic [27:0]  line_addr_t;
   typedef logic [1:0]   word_sel_t;
   typedef logic [3:0]   byte_sel_t;

   // Processor request, held stable until its completion strobe
   typedef struct packed {
      addr_t addr;
      word_t wdata;
      logic  is_word;
      logic  write;
   } cpu_req_t;

   // Write buffer seen by the memory side
   typedef struct packed {
      addr_t addr;
      word_t data;
      logic  is_byte;
   } wbuf_t;

   typedef struct packed {
      word_sel_t offset;
      word_t     data;
   } fill_beat_t;

   typedef enum logic [2:0] {
      st_idle,
      st_store_wait,
      st_fill_wait,
      st_filling,
      st_load_end,
      st_done
   } ctrl_state_t;

   function automatic line_t merge_word(line_t line, word_sel_t sel, word_t data);
      line_t result;
      result = line;
      result[{sel, 5'b00000} +: 32] = data;
      return result;
   endfunction

   function automatic line_t merge_byte(line_t line, byte_sel_t sel, logic [7:0] data);
      line_t result;
      result = line;
      result[{sel, 3'b000} +: 8] = data;
      return result;
   endfunction

   function automatic word_t extract_word(line_t line, word_sel_t sel);
      return line[{sel, 5'b00000} +: 32];
   endfunction

   // Byte loads come back zero extended
   function automatic word_t extract_byte(line_t line, byte_sel_t sel);
      return {24'h000000, line[{sel, 3'b000} +: 8]};
   endfunction

endpackage

`default_nettype wire

// File: src/cpu_coupler.sv
// Cache coupler top level joining the controller, the main cache and the victim cache
`timescale 1ns/1ps
`default_nettype none

module cpu_coupler #(
   parameter int MAIN_LINES   = 64,
   parameter int VICTIM_LINES = 4
) (
   input  logic                   sysclk,
   input  logic                   rst_n,
   input  logic                   nmreq,
   input  logic                   nrw,
   input  logic [1:0]             mas,
   input  coupler_pkg::addr_t     addr,
   input  coupler_pkg::word_t     wdata,
   output coupler_pkg::word_t     rdata,
   output logic                   rd_valid,
   output logic                   nwait,
   input  logic                   st_busy,
   input  logic                   ld_busy,
   input  logic                   fill_req,
   input  coupler_pkg::fill_beat_t fill,
   output logic                   store_trigger,
   output logic                   load_trigger,
   output coupler_pkg::wbuf_t     wbuf
);

   coupler_pkg::cpu_req_t          req;
   logic                           m_write;
   logic                           m_fill;
   logic                           m_install;
   logic                           m_swap;
   logic                           mhit;
   logic                           mvalid;
   coupler_pkg::line_t             mline;
   coupler_pkg::line_addr_t        mtag;
   logic [VICTIM_LINES-1:0]        victim_we;
   logic                           v_update;
   coupler_pkg::line_t             evict_line;
   coupler_pkg::line_addr_t        evict_tag;
   logic                           evict_valid;
   logic [VICTIM_LINES-1:0]        v_match;
   coupler_pkg::line_t             v_lines [VICTIM_LINES];
   logic                           vhit;
   logic [$clog2(VICTIM_LINES)-1:0] vsel;
   coupler_pkg::line_t             vline;

   // mas bit 1 selects a word transfer
   assign req = '{addr: addr, wdata: wdata, is_word: mas[1], write: nrw};

   coupler_ctrl #(
      .VICTIM_LINES (VICTIM_LINES)
   ) u_ctrl (
      .sysclk        (sysclk),
      .rst_n         (rst_n),
      .nmreq         (nmreq),
      .req           (req),
      .st_busy       (st_busy),
      .ld_busy       (ld_busy),
      .fill_req      (fill_req),
      .fill          (fill),
      .mhit          (mhit),
      .mvalid        (mvalid),
      .mline         (mline),
      .mtag          (mtag),
      .vhit          (vhit),
      .vsel          (vsel),
      .vline         (vline),
      .m_write       (m_write),
      .m_fill        (m_fill),
      .m_install     (m_install),
      .m_swap        (m_swap),
      .victim_we     (victim_we),
      .v_update      (v_update),
      .evict_line    (evict_line),
      .evict_tag     (evict_tag),
      .evict_valid   (evict_valid),
      .rdata         (rdata),
      .rd_valid      (rd_valid),
      .nwait         (nwait),
      .store_trigger (store_trigger),
      .load_trigger  (load_trigger),
      .wbuf          (wbuf)
   );

   main_cache #(
      .MAIN_LINES (MAIN_LINES)
   ) u_main_cache (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .req       (req),
      .write     (m_write),
      .fill_we   (m_fill),
      .install   (m_install),
      .swap_in   (m_swap),
      .fill      (fill),
      .swap_line (vline),
      .swap_tag  (req.addr[31:4]),
      .hit       (mhit),
      .valid     (mvalid),
      .line      (mline),
      .tag       (mtag)
   );

   for (genvar i = 0; i < VICTIM_LINES; i++)
   begin : g_victim
      victim_entry u_entry (
         .sysclk    (sysclk),
         .rst_n     (rst_n),
         .we        (victim_we[i]),
         .new_line  (evict_line),
         .new_tag   (evict_tag),
         .new_valid (evict_valid),
         .update    (v_update),
         .req       (req),
         .match     (v_match[i]),
         .valid     (),
         .line      (v_lines[i])
      );
   end

   victim_select #(
      .VICTIM_LINES (VICTIM_LINES)
   ) u_victim_select (
      .match (v_match),
      .lines (v_lines),
      .vhit  (vhit),
      .vsel  (vsel),
      .vline (vline)
   );

endmodule

`default_nettype wire

// File: src/main_cache.sv
// Direct-mapped main cache with line, tag and valid storage, store merge and fill writes
`timescale 1ns/1ps
`default_nettype none

module main_cache #(
   parameter int MAIN_LINES = 64
) (
   input  logic                    sysclk,
   input  logic                    rst_n,
   input  coupler_pkg::cpu_req_t   req,
   input  logic                    write,
   input  logic                    fill_we,
   input  logic                    install,
   input  logic                    swap_in,
   input  coupler_pkg::fill_beat_t fill,
   input  coupler_pkg::line_t      swap_line,
   input  coupler_pkg::line_addr_t swap_tag,
   output logic                    hit,
   output logic                    valid,
   output coupler_pkg::line_t      line,
   output coupler_pkg::line_addr_t tag
);

   localparam int IDX_W = $clog2(MAIN_LINES);

   coupler_pkg::line_t      lines_q [MAIN_LINES];
   coupler_pkg::line_addr_t tags_q  [MAIN_LINES];
   logic [MAIN_LINES-1:0]   valid_q;
   logic [IDX_W-1:0]        idx;

   // Index sits just above the 16-byte line offset
   assign idx = req.addr[4 +: IDX_W];

   assign line  = lines_q[idx];
   assign tag   = tags_q[idx];
   assign valid = valid_q[idx];
   // Tag holds the whole line address
   assign hit   = valid && (tag == req.addr[31:4]);

   always_ff @(posedge sysclk)
   begin
      if (swap_in)
         lines_q[idx] <= swap_line;
      else if (fill_we)
         lines_q[idx] <= coupler_pkg::merge_word(lines_q[idx], fill.offset, fill.data);
      else if (write)
      begin
         if (req.is_word)
            lines_q[idx] <= coupler_pkg::merge_word(lines_q[idx], req.addr[3:2], req.wdata);
         else
            lines_q[idx] <= coupler_pkg::merge_byte(lines_q[idx], req.addr[3:0],
                                                    req.wdata[7:0]);
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (swap_in)
         tags_q[idx] <= swap_tag;
      else if (install)
         tags_q[idx] <= req.addr[31:4];
   end

   always_ff @(posedge sysclk)
   begin
      if (!rst_n)
         valid_q <= '0;
      else if (swap_in || install)
         valid_q[idx] <= 1'b1;
   end

endmodule

`default_nettype wire

// File: src/victim_entry.sv
// One victim cache entry with line, tag, valid, address match and store merge
`timescale 1ns/1ps
`default_nettype none

module victim_entry (
   input  logic                    sysclk,
   input  logic                    rst_n,
   input  logic                    we,
   input  coupler_pkg::line_t      new_line,
   input  coupler_pkg::line_addr_t new_tag,
   input  logic                    new_valid,
   input  logic                    update,
   input  coupler_pkg::cpu_req_t   req,
   output logic                    match,
   output logic                    valid,
   output coupler_pkg::line_t      line
);

   coupler_pkg::line_addr_t tag_q;

   assign match = valid && (tag_q == req.addr[31:4]);

   always_ff @(posedge sysclk)
   begin
      if (we)
      begin
         line  <= new_line;
         tag_q <= new_tag;
      end
      else if (update && match)
      begin
         // Store hit lands in the entry itself
         if (req.is_word)
            line <= coupler_pkg::merge_word(line, req.addr[3:2], req.wdata);
         else
            line <= coupler_pkg::merge_byte(line, req.addr[3:0], req.wdata[7:0]);
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (!rst_n)
         valid <= 1'b0;
      else if (we)
         valid <= new_valid;
   end

endmodule

`default_nettype wire

// File: src/victim_select.sv
// Victim hit, lowest matching entry number and its line
`timescale 1ns/1ps
`default_nettype none

module victim_select #(
   parameter int VICTIM_LINES = 4
) (
   input  logic [VICTIM_LINES-1:0]         match,
   input  coupler_pkg::line_t              lines [VICTIM_LINES],
   output logic                            vhit,
   output logic [$clog2(VICTIM_LINES)-1:0] vsel,
   output coupler_pkg::line_t              vline
);

   localparam int SEL_W = $clog2(VICTIM_LINES);

   assign vhit = |match;

   // Scan downward so the lowest match wins
   always_comb
   begin
      vsel = '0;
      for (int i = VICTIM_LINES - 1; i >= 0; i--)
      begin
         if (match[i])
            vsel = SEL_W'(i);
      end
   end

   assign vline = lines[vsel];

endmodule

`default_nettype wire
